// File: soc_pkg.sv
////////////////////
// soc_pkg
// bus types, address views and register map shared by the SoC blocks
////////////////////
`default_nettype none

package soc_pkg;

	// wishbone classic request from the master, cyc and stb travel apart
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
		logic        we;
	} wb_req_t;

	// slave response
	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

	// address as seen by the tcm
	typedef struct packed {
		logic [3:0]  region;
		logic [15:0] rsvd;
		logic [9:0]  word;
		logic [1:0]  boff;
	} tcm_view_t;

	// address as seen by the peripherals
	typedef struct packed {
		logic [3:0]  region;
		logic [15:0] rsvd0;
		logic [3:0]  psel;
		logic [1:0]  rsvd1;
		logic [3:0]  reg_idx;
		logic [1:0]  boff;
	} periph_view_t;

	typedef union packed {
		tcm_view_t    tcm_view;
		periph_view_t periph_view;
	} bus_addr_u;

	// regions in adr[31:28]
	localparam logic [3:0] REGION_DTCM   = 4'd0;
	localparam logic [3:0] REGION_PERIPH = 4'd4;

	// peripheral select in adr[11:8]
	localparam logic [3:0] PSEL_GPIO  = 4'd0;
	localparam logic [3:0] PSEL_TIMER = 4'd1;

	// gpio registers
	localparam logic [3:0] GPIO_REG_OUT = 4'd0;
	localparam logic [3:0] GPIO_REG_IN  = 4'd1;

	// machine timer registers
	localparam logic [3:0] TMR_REG_MTIME_LO = 4'd0;
	localparam logic [3:0] TMR_REG_MTIME_HI = 4'd1;
	localparam logic [3:0] TMR_REG_CMP_LO   = 4'd2;
	localparam logic [3:0] TMR_REG_CMP_HI   = 4'd3;

	localparam int GPIO_W = 8;

endpackage

`default_nettype wire

// File: wb_decoder.sv
////////////////////
// wb_decoder
// routes wishbone strobes to the slaves, merges responses, flags unmapped
////////////////////
`default_nettype none

module wb_decoder (
	input  logic            clk_in,
	input  logic            rst_n,
	input  logic            wb_cyc,
	input  logic            wb_stb,
	input  soc_pkg::wb_req_t wb_req,
	input  soc_pkg::wb_rsp_t dtcm_rsp,
	input  soc_pkg::wb_rsp_t gpio_rsp,
	input  soc_pkg::wb_rsp_t tmr_rsp,
	output logic            dtcm_stb,
	output logic            gpio_stb,
	output logic            tmr_stb,
	output soc_pkg::wb_rsp_t wb_rsp,
	output logic            wb_err
);
	import soc_pkg::*;

	bus_addr_u addr;
	logic      req_vld;
	logic      hit_dtcm;
	logic      hit_periph;
	logic      hit_gpio;
	logic      hit_tmr;
	logic      unmapped;
	logic      err_q;

	assign addr    = wb_req.adr;
	assign req_vld = wb_cyc & wb_stb;

	// region from the tcm view, select from the peripheral view
	assign hit_dtcm   = (addr.tcm_view.region == REGION_DTCM);
	assign hit_periph = (addr.periph_view.region == REGION_PERIPH);
	assign hit_gpio   = hit_periph && (addr.periph_view.psel == PSEL_GPIO);
	assign hit_tmr    = hit_periph && (addr.periph_view.psel == PSEL_TIMER);
	assign unmapped   = ~(hit_dtcm | hit_gpio | hit_tmr);

	assign dtcm_stb = req_vld & hit_dtcm;
	assign gpio_stb = req_vld & hit_gpio;
	assign tmr_stb  = req_vld & hit_tmr;

	// error follows the same one cycle rule as a slave ack
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req_vld & unmapped & ~err_q;
		end
	end

	assign wb_err = err_q;

	// only the selected slave drives nonzero data, so OR is enough
	assign wb_rsp.dat = dtcm_rsp.dat | gpio_rsp.dat | tmr_rsp.dat;
	assign wb_rsp.ack = dtcm_rsp.ack | gpio_rsp.ack | tmr_rsp.ack;

	// a cycle ends either with ack or with err, never both
	a_ack_err_excl: assert property (@(posedge clk_in) disable iff (!rst_n)
		!(wb_rsp.ack && wb_err));

endmodule

`default_nettype wire

// File: dtcm.sv
////////////////////
// dtcm
// data memory on wishbone with byte lane writes
////////////////////
`default_nettype none

module dtcm #(
	parameter int DTCM_AW = 10
) (
	input  logic            clk_in,
	input  logic            rst_n,
	input  logic            stb,
	input  soc_pkg::wb_req_t req,
	output soc_pkg::wb_rsp_t rsp
);
	import soc_pkg::*;

	logic [31:0]        mem [0:(2**DTCM_AW)-1];
	bus_addr_u          addr;
	logic [DTCM_AW-1:0] idx;
	logic               access;
	logic               ack_q;
	logic [31:0]        rdata_q;

	// word index has to fit the tcm address view
	if (DTCM_AW > 10) begin : g_aw_check
		$error("DTCM_AW wider than the tcm word index");
	end

	assign addr   = req.adr;
	assign idx    = addr.tcm_view.word[DTCM_AW-1:0];
	assign access = stb & ~ack_q;

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// write lands on the same edge that raises ack
	always_ff @(posedge clk_in) begin
		if (access) begin
			if (req.we) begin
				for (int i = 0; i < 4; i++) begin
					if (req.sel[i]) begin
						mem[idx][8*i +: 8] <= req.dat[8*i +: 8];
					end
				end
			end
			rdata_q <= mem[idx];
		end
	end

	// data only while acking, keeps the OR merge clean
	assign rsp.dat = ack_q ? rdata_q : 32'd0;
	assign rsp.ack = ack_q;

	a_ack_single: assert property (@(posedge clk_in) disable iff (!rst_n)
		rsp.ack |=> !rsp.ack);

endmodule

`default_nettype wire

// File: gpio.sv
////////////////////
// gpio
// output register and synchronized input port
////////////////////
`default_nettype none

module gpio (
	input  logic                       clk_in,
	input  logic                       rst_n,
	input  logic                       stb,
	input  soc_pkg::wb_req_t            req,
	input  logic [soc_pkg::GPIO_W-1:0] gpio_in,
	output soc_pkg::wb_rsp_t            rsp,
	output logic [soc_pkg::GPIO_W-1:0] gpio_out
);
	import soc_pkg::*;

	bus_addr_u         addr;
	logic [3:0]        idx;
	logic              access;
	logic              ack_q;
	logic [31:0]       rdata_q;
	logic [GPIO_W-1:0] out_q;
	logic [GPIO_W-1:0] sync1_q;
	logic [GPIO_W-1:0] sync2_q;

	assign addr   = req.adr;
	assign idx    = addr.periph_view.reg_idx;
	assign access = stb & ~ack_q;

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			ack_q   <= 1'b0;
			out_q   <= '0;
			sync1_q <= '0;
			sync2_q <= '0;
		end else begin
			ack_q   <= access;
			// two flop synchronizer on the pins
			sync1_q <= gpio_in;
			sync2_q <= sync1_q;
			// output reg sits in byte lane 0
			if (access && req.we && req.sel[0] && (idx == GPIO_REG_OUT)) begin
				out_q <= req.dat[GPIO_W-1:0];
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (access) begin
			case (idx)
				GPIO_REG_OUT: rdata_q <= {{(32-GPIO_W){1'b0}}, out_q};
				GPIO_REG_IN:  rdata_q <= {{(32-GPIO_W){1'b0}}, sync2_q};
				default:      rdata_q <= 32'd0;
			endcase
		end
	end

	assign rsp.dat  = ack_q ? rdata_q : 32'd0;
	assign rsp.ack  = ack_q;
	assign gpio_out = out_q;

endmodule

`default_nettype wire

// File: core_timer.sv
////////////////////
// core_timer
// machine timer, prescaled 64-bit mtime against mtimecmp
////////////////////
`default_nettype none

module core_timer #(
	parameter int TIMER_DIV = 4
) (
	input  logic            clk_in,
	input  logic            rst_n,
	input  logic            stb,
	input  soc_pkg::wb_req_t req,
	output soc_pkg::wb_rsp_t rsp,
	output logic            timer_int
);
	import soc_pkg::*;

	localparam int PW = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

	bus_addr_u   addr;
	logic [3:0]  idx;
	logic        access;
	logic        wr;
	logic        ack_q;
	logic [31:0] rdata_q;
	logic [PW-1:0] pre_q;
	logic        tick;
	logic [63:0] mtime_q;
	logic [63:0] cmp_q;
	logic        int_q;

	assign addr   = req.adr;
	assign idx    = addr.periph_view.reg_idx;
	assign access = stb & ~ack_q;
	assign wr     = access & req.we;

	// prescaler, one tick every TIMER_DIV cycles
	assign tick = (pre_q == PW'(TIMER_DIV - 1));

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			pre_q <= '0;
		end else if (tick) begin
			pre_q <= '0;
		end else begin
			pre_q <= pre_q + 1'b1;
		end
	end

	// bus write wins over the increment
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			mtime_q <= 64'd0;
		end else if (wr && (idx == TMR_REG_MTIME_LO)) begin
			mtime_q[31:0] <= req.dat;
		end else if (wr && (idx == TMR_REG_MTIME_HI)) begin
			mtime_q[63:32] <= req.dat;
		end else if (tick) begin
			mtime_q <= mtime_q + 64'd1;
		end
	end

	// halves are written whole
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			cmp_q <= '1;
			int_q <= 1'b0;
		end else begin
			ack_q <= access;
			int_q <= (mtime_q >= cmp_q);
			if (wr && (idx == TMR_REG_CMP_LO)) begin
				cmp_q[31:0] <= req.dat;
			end
			if (wr && (idx == TMR_REG_CMP_HI)) begin
				cmp_q[63:32] <= req.dat;
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (access) begin
			case (idx)
				TMR_REG_MTIME_LO: rdata_q <= mtime_q[31:0];
				TMR_REG_MTIME_HI: rdata_q <= mtime_q[63:32];
				TMR_REG_CMP_LO:   rdata_q <= cmp_q[31:0];
				TMR_REG_CMP_HI:   rdata_q <= cmp_q[63:32];
				default:          rdata_q <= 32'd0;
			endcase
		end
	end

	assign rsp.dat   = ack_q ? rdata_q : 32'd0;
	assign rsp.ack   = ack_q;
	assign timer_int = int_q;

	// compare parked at all ones keeps the interrupt quiet
	a_int_parked: assert property (@(posedge clk_in) disable iff (!rst_n)
		((&cmp_q) && !(&mtime_q)) |=> !timer_int);

endmodule

`default_nettype wire

// File: krv_soc.sv
////////////////////
// krv_soc
// top level, wishbone decoder with dtcm, gpio and machine timer
////////////////////
`default_nettype none

module krv_soc #(
	parameter int DTCM_AW   = 10,
	parameter int TIMER_DIV = 4
) (
	input  logic                       clk_in,
	input  logic                       rst_n,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  soc_pkg::wb_req_t            wb_req,
	input  logic [soc_pkg::GPIO_W-1:0] gpio_in,
	output soc_pkg::wb_rsp_t            wb_rsp,
	output logic                       wb_err,
	output logic [soc_pkg::GPIO_W-1:0] gpio_out,
	output logic                       timer_int
);
	import soc_pkg::*;

	// per slave strobes and responses
	logic    dtcm_stb;
	logic    gpio_stb;
	logic    tmr_stb;
	wb_rsp_t dtcm_rsp;
	wb_rsp_t gpio_rsp;
	wb_rsp_t tmr_rsp;

	wb_decoder u_wb_decoder (
		.clk_in   (clk_in),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_req   (wb_req),
		.dtcm_rsp (dtcm_rsp),
		.gpio_rsp (gpio_rsp),
		.tmr_rsp  (tmr_rsp),
		.dtcm_stb (dtcm_stb),
		.gpio_stb (gpio_stb),
		.tmr_stb  (tmr_stb),
		.wb_rsp   (wb_rsp),
		.wb_err   (wb_err)
	);

	dtcm #(
		.DTCM_AW (DTCM_AW)
	) u_dtcm (
		.clk_in (clk_in),
		.rst_n  (rst_n),
		.stb    (dtcm_stb),
		.req    (wb_req),
		.rsp    (dtcm_rsp)
	);

	gpio u_gpio (
		.clk_in   (clk_in),
		.rst_n    (rst_n),
		.stb      (gpio_stb),
		.req      (wb_req),
		.gpio_in  (gpio_in),
		.rsp      (gpio_rsp),
		.gpio_out (gpio_out)
	);

	core_timer #(
		.TIMER_DIV (TIMER_DIV)
	) u_core_timer (
		.clk_in    (clk_in),
		.rst_n     (rst_n),
		.stb       (tmr_stb),
		.req       (wb_req),
		.rsp       (tmr_rsp),
		.timer_int (timer_int)
	);

endmodule

`default_nettype wire

// File: tb_krv_soc.sv
////////////////////
// tb_krv_soc
// wishbone master testbench for the SoC with a dtcm reference model
////////////////////
`default_nettype none

module tb_krv_soc;
	import soc_pkg::*;

	localparam int CLK_HALF    = 2;
	localparam int CLK_PERIOD  = 2 * CLK_HALF;
	// krv_soc default prescale
	localparam int TIMER_DIV   = 4;
	localparam int ACK_TIMEOUT = 16;
	localparam int INT_TIMEOUT = 200;

	logic              clk_in;
	logic              rst_n;
	logic              wb_cyc;
	logic              wb_stb;
	wb_req_t           wb_req;
	logic [GPIO_W-1:0] gpio_in;
	wb_rsp_t           wb_rsp;
	logic              wb_err;
	logic [GPIO_W-1:0] gpio_out;
	logic              timer_int;

	integer      seed = 3368;
	int          error_count = 0;
	int          check_count = 0;
	logic [31:0] ref_mem [0:1023];
	logic [9:0]  widx [0:31];

	// comparisons waiting for the checker
	string       name_q [$];
	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];

	krv_soc dut_i (
		.clk_in    (clk_in),
		.rst_n     (rst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_req    (wb_req),
		.gpio_in   (gpio_in),
		.wb_rsp    (wb_rsp),
		.wb_err    (wb_err),
		.gpio_out  (gpio_out),
		.timer_int (timer_int)
	);

	always #CLK_HALF clk_in = ~clk_in;

	// word after a write with byte selects
	function automatic logic [31:0] expected_word(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] sel);
		logic [31:0] res;
		res = old_word;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				res[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [31:0] dtcm_addr(input logic [9:0] word);
		return {REGION_DTCM, 16'd0, word, 2'b00};
	endfunction

	function automatic logic [31:0] reg_addr(input logic [3:0] psel, input logic [3:0] idx);
		return {REGION_PERIPH, 16'd0, psel, 2'b00, idx, 2'b00};
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			$display("ERROR t=%0t %s got=%h expected=%h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic queue_check(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		error_count++;
	endtask

	task automatic end_of_test();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	// one classic cycle, held until ack or err
	task automatic transfer(input logic [31:0] adr, input logic we, input logic [31:0] dat,
		input logic [3:0] sel, output logic [31:0] rdata, output logic ack, output logic err);
		int waited;
		@(posedge clk_in);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_req <= '{adr: adr, dat: dat, sel: sel, we: we};
		waited = 0;
		@(negedge clk_in);
		while (!(wb_rsp.ack || wb_err) && waited < ACK_TIMEOUT) begin
			@(negedge clk_in);
			waited++;
		end
		rdata = wb_rsp.dat;
		ack = wb_rsp.ack;
		err = wb_err;
		if (!(ack || err)) begin
			note_failure($sformatf("timeout: no ack or err for address %h", adr));
			end_of_test();
		end else begin
			@(posedge clk_in);
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
		end
	endtask

	task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		logic [31:0] rdata;
		logic        ack;
		logic        err;
		transfer(adr, 1'b1, dat, sel, rdata, ack, err);
		if (err) note_failure($sformatf("bus error on write to %h", adr));
	endtask

	task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdata);
		logic ack;
		logic err;
		transfer(adr, 1'b0, 32'd0, 4'hf, rdata, ack, err);
		if (err) note_failure($sformatf("bus error on read from %h", adr));
	endtask

	always @(negedge clk_in) begin
		while (got_q.size() != 0) begin
			check_equal(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
		end
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] rd2;
		logic [31:0] data;
		logic [31:0] rnd;
		logic [3:0]  sel;
		logic [4:0]  k;
		logic        ack;
		logic        err;
		int          waited;
		time         t0;
		longint      elapsed;

		clk_in  = 1'b0;
		rst_n   = 1'b0;
		wb_cyc  = 1'b0;
		wb_stb  = 1'b0;
		wb_req  = '0;
		gpio_in = '0;
		repeat (8) @(posedge clk_in);
		rst_n <= 1'b1;
		@(negedge clk_in);

		queue_check("gpio_out", 32'(gpio_out), 32'd0);
		queue_check("timer_int", 32'(timer_int), 32'd0);
		bus_read(reg_addr(PSEL_TIMER, TMR_REG_CMP_LO), rd);
		queue_check("wb_rsp.dat", rd, 32'hffff_ffff);

		// full words first so later partial writes merge into known data
		for (int i = 0; i < 32; i++) begin
			rnd = $random(seed);
			widx[i] = rnd[9:0];
			data = $random(seed);
			bus_write(dtcm_addr(widx[i]), data, 4'hf);
			ref_mem[widx[i]] = data;
		end
		for (int i = 0; i < 32; i++) begin
			bus_read(dtcm_addr(widx[i]), rd);
			queue_check("wb_rsp.dat", rd, ref_mem[widx[i]]);
		end
		for (int i = 0; i < 32; i++) begin
			rnd = $random(seed);
			k = rnd[4:0];
			sel = rnd[8:5];
			data = $random(seed);
			bus_write(dtcm_addr(widx[k]), data, sel);
			ref_mem[widx[k]] = expected_word(ref_mem[widx[k]], data, sel);
			bus_read(dtcm_addr(widx[k]), rd);
			queue_check("wb_rsp.dat", rd, ref_mem[widx[k]]);
		end

		// gpio out then in
		bus_write(reg_addr(PSEL_GPIO, GPIO_REG_OUT), 32'h0000_00a5, 4'b0001);
		queue_check("gpio_out", 32'(gpio_out), 32'h0000_00a5);
		bus_read(reg_addr(PSEL_GPIO, GPIO_REG_OUT), rd);
		queue_check("wb_rsp.dat", rd, 32'h0000_00a5);
		rnd = $random(seed);
		@(posedge clk_in);
		gpio_in <= rnd[7:0];
		repeat (4) @(posedge clk_in);
		bus_read(reg_addr(PSEL_GPIO, GPIO_REG_IN), rd);
		queue_check("wb_rsp.dat", rd, {24'd0, rnd[7:0]});

		// mtime counts from zero
		bus_write(reg_addr(PSEL_TIMER, TMR_REG_MTIME_HI), 32'd0, 4'hf);
		t0 = $time;
		bus_write(reg_addr(PSEL_TIMER, TMR_REG_MTIME_LO), 32'd0, 4'hf);
		repeat (40) @(posedge clk_in);
		bus_read(reg_addr(PSEL_TIMER, TMR_REG_MTIME_LO), rd);
		elapsed = longint'(($time - t0) / CLK_PERIOD);
		if (rd == 32'd0 || longint'(rd) > elapsed / TIMER_DIV) begin
			note_failure($sformatf("mtime %0d out of range after %0d cycles", rd, elapsed));
		end
		bus_read(reg_addr(PSEL_TIMER, TMR_REG_MTIME_LO), rd2);
		if (rd2 < rd) note_failure($sformatf("mtime went back from %0d to %0d", rd, rd2));

		// compare at 20, hi half last so the low half never matches alone
		bus_write(reg_addr(PSEL_TIMER, TMR_REG_MTIME_HI), 32'd0, 4'hf);
		bus_write(reg_addr(PSEL_TIMER, TMR_REG_MTIME_LO), 32'd0, 4'hf);
		bus_write(reg_addr(PSEL_TIMER, TMR_REG_CMP_LO), 32'd20, 4'hf);
		bus_write(reg_addr(PSEL_TIMER, TMR_REG_CMP_HI), 32'd0, 4'hf);
		waited = 0;
		while (!timer_int && waited < INT_TIMEOUT) begin
			@(negedge clk_in);
			waited++;
		end
		if (!timer_int) note_failure("timer_int did not rise with mtimecmp at 20");
		bus_read(reg_addr(PSEL_TIMER, TMR_REG_MTIME_LO), rd);
		if (rd < 32'd20) note_failure($sformatf("timer_int high with mtime at %0d", rd));
		bus_write(reg_addr(PSEL_TIMER, TMR_REG_CMP_HI), 32'hffff_ffff, 4'hf);
		bus_write(reg_addr(PSEL_TIMER, TMR_REG_CMP_LO), 32'hffff_ffff, 4'hf);
		waited = 0;
		while (timer_int && waited < ACK_TIMEOUT) begin
			@(negedge clk_in);
			waited++;
		end
		queue_check("timer_int", 32'(timer_int), 32'd0);

		// region 8 is not mapped
		transfer(32'h8000_0000, 1'b0, 32'd0, 4'hf, rd, ack, err);
		queue_check("wb_err", 32'(err), 32'd1);
		queue_check("wb_rsp.ack", 32'(ack), 32'd0);

		waited = 0;
		while (got_q.size() != 0 && waited < 4) begin
			@(negedge clk_in);
			waited++;
		end
		if (got_q.size() != 0) note_failure("comparisons still pending at the end of the run");
		end_of_test();
	end

endmodule

`default_nettype wire

// File: src.f
soc_pkg.sv
wb_decoder.sv
dtcm.sv
gpio.sv
core_timer.sv
krv_soc.sv
tb_krv_soc.sv

// File: Makefile
# Verilator build and run for the krv_soc testbench

VERILATOR ?= verilator
TOP       ?= tb_krv_soc
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
